//--- Bender.yml
package:
  name: mem_system

sources:
  - target: any(rtl, test)
    files:
      - src/cache_geom_pkg.sv
      - src/mem_ctrl_pkg.sv
      - src/mem_bus_if.sv
      - src/cache_array.sv
      - src/banked_mem.sv
      - src/cache_ctrl.sv
      - src/mem_system.sv
  - target: test
    files:
      - testbench/mem_system_assertions.sv
      - testbench/mem_system_tb.sv

//--- flist.f
src/cache_geom_pkg.sv
src/mem_ctrl_pkg.sv
src/mem_bus_if.sv
src/cache_array.sv
src/banked_mem.sv
src/cache_ctrl.sv
src/mem_system.sv
testbench/mem_system_assertions.sv
testbench/mem_system_tb.sv

//--- src/banked_mem.sv
`timescale 1ns/10ps
`default_nettype none

module banked_mem #(
   parameter int BANK_BUSY = mem_ctrl_pkg::DEF_BANK_BUSY
) (
   input  logic   clk,
   input  logic   rst,
   mem_bus_if.mem bus
);

   localparam int BANKS = mem_ctrl_pkg::BANKS;
   localparam int LAT = mem_ctrl_pkg::READ_LATENCY;
   localparam int BSEL_W = $clog2(BANKS);
   // Remaining word address bits select the row in a bank
   localparam int ROW_W = cache_geom_pkg::WADDR_W - BSEL_W;
   localparam int ROWS = 1 << ROW_W;
   localparam int CNT_W = $clog2(BANK_BUSY + 1);

   logic [BSEL_W-1:0] bank_sel;
   logic [ROW_W-1:0] row;
   logic [BANKS-1:0] bank_busy;
   logic access;
   cache_geom_pkg::word_t bank_word [BANKS];
   // Read data delay line
   cache_geom_pkg::word_t lat_q [LAT];

   // Interleave on the low word address bits
   assign bank_sel = bus.addr[BSEL_W-1:0];
   assign row      = bus.addr[cache_geom_pkg::WADDR_W-1:BSEL_W];

   // Stall straight from the addressed bank's timer
   assign bus.stall = bank_busy[bank_sel];
   assign access    = (bus.rd || bus.wr) && !bus.stall;

   for (genvar b = 0; b < BANKS; b++) begin : g_bank
      cache_geom_pkg::word_t mem_q [ROWS];
      logic [CNT_W-1:0] busy_q;
      logic bank_acc;

      assign bank_acc = access && (bank_sel == BSEL_W'(b));

      // Busy down-counter, reloaded on every access
      always_ff @(posedge clk) begin
         if (rst) begin
            busy_q <= '0;
         end else if (bank_acc) begin
            busy_q <= CNT_W'(BANK_BUSY);
         end else if (busy_q != '0) begin
            busy_q <= busy_q - 1'b1;
         end
      end

      always_ff @(posedge clk) begin
         if (bank_acc && bus.wr) begin
            mem_q[row] <= bus.wdata;
         end
      end

      assign bank_word[b] = mem_q[row];
      assign bank_busy[b] = (busy_q != '0);
   end

   // Stage 0 captures the bank word, later stages just shift
   // Other banks may start reads while earlier data is still in the line
   always_ff @(posedge clk) begin
      if (access && bus.rd) begin
         lat_q[0] <= bank_word[bank_sel];
      end
      for (int i = 1; i < LAT; i++) begin
         lat_q[i] <= lat_q[i-1];
      end
   end

   assign bus.rdata = lat_q[LAT-1];

endmodule

`default_nettype wire

//--- src/cache_array.sv
`timescale 1ns/10ps
`default_nettype none

module cache_array (
   input  logic                      clk,
   input  logic                      rst,
   // Lookup port
   input  logic                      lookup,
   input  cache_geom_pkg::index_t    lk_index,
   input  cache_geom_pkg::tag_t      lk_tag,
   input  cache_geom_pkg::word_sel_t lk_word,
   // Word write port, same line as the lookup index
   input  logic                      wr_en,
   input  cache_geom_pkg::word_t     wr_data,
   input  cache_geom_pkg::word_sel_t wr_word,
   input  logic                      wr_dirty,
   input  logic                      wr_fill,
   // Lookup results, one cycle after lookup
   output logic                      hit,
   output logic                      valid,
   output logic                      dirty,
   output cache_geom_pkg::tag_t      stored_tag,
   output cache_geom_pkg::word_t     rd_word
);

   localparam int LINES = cache_geom_pkg::LINES;
   localparam int WORDS = cache_geom_pkg::LINES * cache_geom_pkg::WORDS_PER_LINE;
   localparam int PTR_W = cache_geom_pkg::INDEX_W + cache_geom_pkg::WORD_SEL_W;

   cache_geom_pkg::tag_t tag_mem [LINES];
   // Data flattened as {index, word}
   cache_geom_pkg::word_t data_mem [WORDS];
   logic [LINES-1:0] valid_q;
   logic [LINES-1:0] dirty_q;

   logic hit_q;
   logic valid_out_q;
   logic dirty_out_q;
   cache_geom_pkg::tag_t tag_out_q;
   cache_geom_pkg::word_t word_out_q;

   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] wr_ptr;

   assign rd_ptr = {lk_index, lk_word};
   assign wr_ptr = {lk_index, wr_word};

   // Line state bits
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (wr_en) begin
         if (wr_fill) begin
            // Fresh line from memory is clean
            valid_q[lk_index] <= 1'b1;
            dirty_q[lk_index] <= 1'b0;
         end else if (wr_dirty) begin
            dirty_q[lk_index] <= 1'b1;
         end
      end
   end

   // Tag and data storage
   always_ff @(posedge clk) begin
      if (wr_en) begin
         data_mem[wr_ptr] <= wr_data;
      end
      // Fill claims the line for the new tag
      if (wr_en && wr_fill) begin
         tag_mem[lk_index] <= lk_tag;
      end
   end

   // Registered lookup flags
   always_ff @(posedge clk) begin
      if (rst) begin
         hit_q       <= 1'b0;
         valid_out_q <= 1'b0;
         dirty_out_q <= 1'b0;
      end else if (lookup) begin
         valid_out_q <= valid_q[lk_index];
         dirty_out_q <= dirty_q[lk_index];
         hit_q       <= valid_q[lk_index] && (tag_mem[lk_index] == lk_tag);
      end
   end

   // Registered lookup payload
   always_ff @(posedge clk) begin
      if (lookup) begin
         tag_out_q  <= tag_mem[lk_index];
         word_out_q <= data_mem[rd_ptr];
      end
   end

   assign hit        = hit_q;
   assign valid      = valid_out_q;
   assign dirty      = dirty_out_q;
   assign stored_tag = tag_out_q;
   assign rd_word    = word_out_q;

endmodule

`default_nettype wire

//--- src/cache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl (
   input  logic                      clk,
   input  logic                      rst,
   // Host side
   input  cache_geom_pkg::addr_t     addr,
   input  cache_geom_pkg::word_t     wdata,
   input  logic                      rd,
   input  logic                      wr,
   output cache_geom_pkg::word_t     rdata,
   output logic                      done,
   output logic                      stall,
   output logic                      cache_hit,
   output logic                      err,
   // Cache array lookup
   output logic                      lookup,
   output cache_geom_pkg::index_t    lk_index,
   output cache_geom_pkg::tag_t      lk_tag,
   output cache_geom_pkg::word_sel_t lk_word,
   // Cache array write
   output logic                      wr_en,
   output cache_geom_pkg::word_t     wr_data,
   output cache_geom_pkg::word_sel_t wr_word,
   output logic                      wr_dirty,
   output logic                      wr_fill,
   // Cache array results
   input  logic                      hit,
   input  logic                      valid,
   input  logic                      dirty,
   input  cache_geom_pkg::tag_t      stored_tag,
   input  cache_geom_pkg::word_t     rd_word,
   // Banked memory
   mem_bus_if.ctrl                   mem
);

   localparam int LAT = mem_ctrl_pkg::READ_LATENCY;
   localparam cache_geom_pkg::word_sel_t LAST_WORD =
      cache_geom_pkg::word_sel_t'(cache_geom_pkg::WORDS_PER_LINE - 1);

   mem_ctrl_pkg::ctrl_state_t state_q;
   mem_ctrl_pkg::ctrl_state_t state_d;

   cache_geom_pkg::addr_fields_t host_f;
   cache_geom_pkg::addr_fields_t req_q;
   cache_geom_pkg::word_t req_wdata_q;
   logic req_wr_q;
   cache_geom_pkg::word_t rdata_q;

   // Word counter shared by write-back and fill bursts
   cache_geom_pkg::word_sel_t cnt_q;
   // Victim word for cnt_q sits on rd_word
   logic wb_ready_q;
   // Fill reads in flight, one slot per cycle of read latency
   logic [LAT-1:0] pend_vld_q;
   cache_geom_pkg::word_sel_t pend_word_q [LAT];

   logic accept;
   logic bad_req;
   logic wb_issue;
   logic fill_issue;
   logic install;
   cache_geom_pkg::word_sel_t install_word;

   assign host_f = cache_geom_pkg::addr_fields_t'(addr);

   // Exactly one strobe starts a request, both is fatal
   assign accept  = (state_q == mem_ctrl_pkg::IDLE) && (rd ^ wr);
   assign bad_req = (state_q == mem_ctrl_pkg::IDLE) && rd && wr;

   // Memory accesses only go out while the bank is free
   assign wb_issue   = (state_q == mem_ctrl_pkg::WB_WRITE) && wb_ready_q && !mem.stall;
   assign fill_issue = (state_q == mem_ctrl_pkg::FILL_READ) && !mem.stall;

   // Oldest fill read returns this cycle
   assign install      = pend_vld_q[LAT-1];
   assign install_word = pend_word_q[LAT-1];

   always_comb begin
      state_d = state_q;
      case (state_q)
         mem_ctrl_pkg::IDLE: begin
            if (bad_req) begin
               state_d = mem_ctrl_pkg::ERROR;
            end else if (accept) begin
               state_d = mem_ctrl_pkg::COMPARE;
            end
         end
         mem_ctrl_pkg::COMPARE: begin
            // Lookup result from the IDLE cycle is valid here
            if (hit) begin
               state_d = mem_ctrl_pkg::DONE;
            end else if (valid && dirty) begin
               state_d = mem_ctrl_pkg::WB_WRITE;
            end else begin
               state_d = mem_ctrl_pkg::FILL_READ;
            end
         end
         mem_ctrl_pkg::WB_WRITE: begin
            if (wb_issue && (cnt_q == LAST_WORD)) begin
               state_d = mem_ctrl_pkg::FILL_READ;
            end
         end
         mem_ctrl_pkg::FILL_READ: begin
            if (fill_issue && (cnt_q == LAST_WORD)) begin
               state_d = mem_ctrl_pkg::FILL_INSTALL;
            end
         end
         mem_ctrl_pkg::FILL_INSTALL: begin
            // Reads go out in word order, last word closes the fill
            if (install && (install_word == LAST_WORD)) begin
               state_d = mem_ctrl_pkg::DONE;
            end
         end
         mem_ctrl_pkg::DONE: begin
            state_d = mem_ctrl_pkg::IDLE;
         end
         mem_ctrl_pkg::ERROR: begin
            // Sticky until reset
            state_d = mem_ctrl_pkg::ERROR;
         end
         default: begin
            state_d = mem_ctrl_pkg::ERROR;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q    <= mem_ctrl_pkg::IDLE;
         cnt_q      <= '0;
         wb_ready_q <= 1'b0;
         pend_vld_q <= '0;
      end else begin
         state_q <= state_d;
         // First write-back cycle only primes the array read
         wb_ready_q <= (state_q == mem_ctrl_pkg::WB_WRITE);
         pend_vld_q <= (pend_vld_q << 1) | LAT'(fill_issue);
         if (state_q == mem_ctrl_pkg::COMPARE) begin
            cnt_q <= '0;
         end else if (wb_issue || fill_issue) begin
            // Wraps to 0 after write-back, ready for the fill
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   // Request capture and fill word tags
   always_ff @(posedge clk) begin
      if (accept) begin
         req_q       <= host_f;
         req_wdata_q <= wdata;
         req_wr_q    <= wr;
      end
      pend_word_q[0] <= cnt_q;
      for (int i = 1; i < LAT; i++) begin
         pend_word_q[i] <= pend_word_q[i-1];
      end
   end

   // Read data held for the done cycle
   always_ff @(posedge clk) begin
      if ((state_q == mem_ctrl_pkg::COMPARE) && hit && !req_wr_q) begin
         rdata_q <= rd_word;
      end else if (install && (install_word == req_q.word) && !req_wr_q) begin
         // Miss read takes its word straight off the fill
         rdata_q <= mem.rdata;
      end
   end

   // Host outputs
   assign rdata     = rdata_q;
   assign done      = (state_q == mem_ctrl_pkg::DONE);
   assign err       = (state_q == mem_ctrl_pkg::ERROR);
   assign cache_hit = (state_q == mem_ctrl_pkg::COMPARE) && hit;
   assign stall     = (state_q == mem_ctrl_pkg::COMPARE) ||
                      (state_q == mem_ctrl_pkg::WB_WRITE) ||
                      (state_q == mem_ctrl_pkg::FILL_READ) ||
                      (state_q == mem_ctrl_pkg::FILL_INSTALL);

   // Lookup on acceptance and for each victim word
   assign lookup   = accept || (state_q == mem_ctrl_pkg::WB_WRITE);
   assign lk_index = (state_q == mem_ctrl_pkg::IDLE) ? host_f.index : req_q.index;
   assign lk_tag   = (state_q == mem_ctrl_pkg::IDLE) ? host_f.tag : req_q.tag;

   always_comb begin
      if (state_q == mem_ctrl_pkg::IDLE) begin
         lk_word = host_f.word;
      end else if (state_q == mem_ctrl_pkg::WB_WRITE) begin
         // Fetch ahead so back-to-back writes need no gap
         lk_word = wb_issue ? cache_geom_pkg::word_sel_t'(cnt_q + 1'b1) : cnt_q;
      end else begin
         lk_word = req_q.word;
      end
   end

   // Fill installs, or the host word in the done cycle
   assign wr_en    = install || ((state_q == mem_ctrl_pkg::DONE) && req_wr_q);
   assign wr_fill  = install;
   assign wr_dirty = !install;
   assign wr_word  = install ? install_word : req_q.word;
   assign wr_data  = install ? mem.rdata : req_wdata_q;

   // Victim line goes back under its stored tag, fill uses the request tag
   assign mem.addr  = (state_q == mem_ctrl_pkg::WB_WRITE) ?
                      {stored_tag, req_q.index, cnt_q} :
                      {req_q.tag, req_q.index, cnt_q};
   assign mem.wdata = rd_word;
   assign mem.rd    = fill_issue;
   assign mem.wr    = wb_issue;

endmodule

`default_nettype wire

//--- src/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

   // Host address and data widths
   localparam int ADDR_W = 16;
   localparam int WORD_W = 16;
   // Word address drops the byte bit
   localparam int WADDR_W = ADDR_W - 1;

   // Address field widths, byte bit 0 ignored
   localparam int TAG_W = 5;
   localparam int INDEX_W = 8;
   localparam int WORD_SEL_W = 2;

   // Direct-mapped geometry
   localparam int LINES = 1 << INDEX_W;
   localparam int WORDS_PER_LINE = 1 << WORD_SEL_W;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [WORD_W-1:0] word_t;
   typedef logic [WADDR_W-1:0] waddr_t;
   typedef logic [TAG_W-1:0] tag_t;
   typedef logic [INDEX_W-1:0] index_t;
   typedef logic [WORD_SEL_W-1:0] word_sel_t;

   // Byte address split into its fields, MSB first
   typedef struct packed {
      tag_t tag;
      index_t index;
      word_sel_t word;
      logic byte_sel;
   } addr_fields_t;

endpackage

`default_nettype wire

//--- src/mem_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

// Word accesses from the cache controller to banked memory
interface mem_bus_if;

   // Word address, low bits pick the bank
   cache_geom_pkg::waddr_t addr;
   cache_geom_pkg::word_t wdata;
   logic rd;
   logic wr;
   // Addressed bank still busy
   logic stall;
   // Valid READ_LATENCY cycles after an accepted read
   cache_geom_pkg::word_t rdata;

   modport ctrl (
      output addr,
      output wdata,
      output rd,
      output wr,
      input  stall,
      input  rdata
   );

   modport mem (
      input  addr,
      input  wdata,
      input  rd,
      input  wr,
      output stall,
      output rdata
   );

endinterface

`default_nettype wire

//--- src/mem_ctrl_pkg.sv
`default_nettype none

package mem_ctrl_pkg;

   // Cache controller FSM states
   typedef enum logic [3:0] {
      IDLE,
      COMPARE,
      WB_WRITE,
      FILL_READ,
      FILL_INSTALL,
      DONE,
      ERROR
   } ctrl_state_t;

   // Interleave factor of main memory
   localparam int BANKS = 4;
   // Cycles a bank stays busy after an access, unless overridden
   localparam int DEF_BANK_BUSY = 4;
   // Accepted read to valid rdata
   localparam int READ_LATENCY = 2;

endpackage

`default_nettype wire

//--- src/mem_system.sv
`timescale 1ns/10ps
`default_nettype none

module mem_system #(
   parameter int BANK_BUSY = mem_ctrl_pkg::DEF_BANK_BUSY
) (
   input  logic                  clk,
   input  logic                  rst,
   input  cache_geom_pkg::addr_t addr,
   input  cache_geom_pkg::word_t wdata,
   input  logic                  rd,
   input  logic                  wr,
   output cache_geom_pkg::word_t rdata,
   output logic                  done,
   output logic                  stall,
   output logic                  cache_hit,
   output logic                  err
);

   // Controller to cache array
   logic lookup;
   cache_geom_pkg::index_t lk_index;
   cache_geom_pkg::tag_t lk_tag;
   cache_geom_pkg::word_sel_t lk_word;
   logic wr_en;
   cache_geom_pkg::word_t wr_data;
   cache_geom_pkg::word_sel_t wr_word;
   logic wr_dirty;
   logic wr_fill;
   // Cache array back to controller
   logic hit;
   logic valid;
   logic dirty;
   cache_geom_pkg::tag_t stored_tag;
   cache_geom_pkg::word_t rd_word;

   mem_bus_if mem_bus_i ();

   cache_ctrl ctrl_i (
      .clk        (clk),
      .rst        (rst),
      .addr       (addr),
      .wdata      (wdata),
      .rd         (rd),
      .wr         (wr),
      .rdata      (rdata),
      .done       (done),
      .stall      (stall),
      .cache_hit  (cache_hit),
      .err        (err),
      .lookup     (lookup),
      .lk_index   (lk_index),
      .lk_tag     (lk_tag),
      .lk_word    (lk_word),
      .wr_en      (wr_en),
      .wr_data    (wr_data),
      .wr_word    (wr_word),
      .wr_dirty   (wr_dirty),
      .wr_fill    (wr_fill),
      .hit        (hit),
      .valid      (valid),
      .dirty      (dirty),
      .stored_tag (stored_tag),
      .rd_word    (rd_word),
      .mem        (mem_bus_i.ctrl)
   );

   cache_array array_i (
      .clk        (clk),
      .rst        (rst),
      .lookup     (lookup),
      .lk_index   (lk_index),
      .lk_tag     (lk_tag),
      .lk_word    (lk_word),
      .wr_en      (wr_en),
      .wr_data    (wr_data),
      .wr_word    (wr_word),
      .wr_dirty   (wr_dirty),
      .wr_fill    (wr_fill),
      .hit        (hit),
      .valid      (valid),
      .dirty      (dirty),
      .stored_tag (stored_tag),
      .rd_word    (rd_word)
   );

   // Bank busy time set here only
   banked_mem #(
      .BANK_BUSY (BANK_BUSY)
   ) mem_i (
      .clk (clk),
      .rst (rst),
      .bus (mem_bus_i.mem)
   );

endmodule

`default_nettype wire

//--- testbench/mem_system_assertions.sv
`timescale 1ns/10ps
`default_nettype none

// Protocol properties, bound into mem_system
module mem_system_assertions (
   input logic clk,
   input logic rst,
   // Host side
   input logic rd,
   input logic wr,
   input logic done,
   input logic err,
   input logic stall,
   // Controller to banked memory
   input logic mem_rd,
   input logic mem_wr,
   input logic mem_stall
);

   // Failed property count, read by the testbench at the end
   int fail_count = 0;

   // Success and sticky error are exclusive
   done_err_excl: assert property (@(posedge clk) disable iff (rst)
      !(done && err))
      else begin
         $error("done and err high in the same cycle");
         fail_count++;
      end

   // Stall only rises after a host request, so it stays low from reset on
   stall_needs_request: assert property (@(posedge clk) disable iff (rst)
      (!$past(stall) && !$past(rd || wr)) |-> !stall)
      else begin
         $error("stall rose with no host request");
         fail_count++;
      end

   // One access type at a time on the memory bus
   mem_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
      !(mem_rd && mem_wr))
      else begin
         $error("memory rd and wr high together");
         fail_count++;
      end

   // Controller must hold off while the bank is busy
   no_issue_on_stall: assert property (@(posedge clk) disable iff (rst)
      (mem_rd || mem_wr) |-> !mem_stall)
      else begin
         $error("memory access issued while stall was high");
         fail_count++;
      end

endmodule

`default_nettype wire

//--- testbench/mem_system_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_system_tb;

   localparam int HALF_PERIOD = 4;
   localparam int DRIVE_DELAY = 1;
   localparam int RESET_CYCLES = 16;
   // Request sampled at N, done during N+2
   localparam int HIT_LATENCY = 2;
   // Upper bound on one request with write-back and fill
   localparam int MISS_BOUND = 60;
   localparam int RANDOM_OPS = 200;
   localparam int ERROR_HOLD = 12;
   // Requests over all tests including the bad one
   localparam int N_REQUESTS = 2 + 8 + 4 + RANDOM_OPS + 3;
   localparam int EXTRA_CYCLES = 2 * RESET_CYCLES + ERROR_HOLD + 32;

   logic clk;
   logic rst;
   cache_geom_pkg::addr_t addr;
   cache_geom_pkg::word_t wdata;
   logic rd;
   logic wr;
   cache_geom_pkg::word_t rdata;
   logic done;
   logic stall;
   logic cache_hit;
   logic err;

   // Expected memory contents by word-aligned byte address
   cache_geom_pkg::word_t ref_mem [cache_geom_pkg::addr_t];
   logic [31:0] rng_q = 32'h349bfbe1;

   mem_system #(
      .BANK_BUSY (mem_ctrl_pkg::DEF_BANK_BUSY)
   ) dut_i (
      .clk       (clk),
      .rst       (rst),
      .addr      (addr),
      .wdata     (wdata),
      .rd        (rd),
      .wr        (wr),
      .rdata     (rdata),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   bind mem_system mem_system_assertions props_i (
      .clk       (clk),
      .rst       (rst),
      .rd        (rd),
      .wr        (wr),
      .done      (done),
      .err       (err),
      .stall     (stall),
      .mem_rd    (mem_bus_i.rd),
      .mem_wr    (mem_bus_i.wr),
      .mem_stall (mem_bus_i.stall)
   );

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic stop_with_failure();
      $display("TEST FAILED");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_value(input string test, input string what,
                              input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else begin
         $display("CHECK FAILED %s: %s expected %0h actual %0h", test, what, exp, act);
         stop_with_failure();
      end
   endtask

   // Ends 1 ns after the edge that releases reset
   task automatic apply_reset();
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      rst = 1'b0;
   endtask

   // One host request entered and left 1 ns after a rising edge
   task automatic issue_request(input string test, input bit is_wr,
                                input cache_geom_pkg::addr_t a, input cache_geom_pkg::word_t d,
                                output cache_geom_pkg::word_t data, output bit hit,
                                output int lat);
      bit seen_done;
      seen_done = 1'b0;
      hit = 1'b0;
      lat = 0;
      data = '0;
      addr = a;
      wdata = d;
      rd = !is_wr;
      wr = is_wr;
      while (!seen_done) begin
         @(posedge clk);
         lat++;
         // Outputs settled mid-cycle
         @(negedge clk);
         if (cache_hit) begin
            hit = 1'b1;
         end
         if (done) begin
            seen_done = 1'b1;
            data = rdata;
         end else begin
            check_value(test, "stall while waiting", 1'b1, stall);
            if (lat >= MISS_BOUND) begin
               $display("%s: no done within %0d cycles of the request", test, MISS_BOUND);
               stop_with_failure();
            end
         end
      end
      // Strobe drops in the cycle after done
      @(posedge clk);
      #DRIVE_DELAY;
      rd = 1'b0;
      wr = 1'b0;
      // One idle cycle between requests
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic do_write(input string test, input cache_geom_pkg::addr_t a,
                           input cache_geom_pkg::word_t d, output bit hit);
      cache_geom_pkg::word_t unused;
      int lat;
      issue_request(test, 1'b1, a, d, unused, hit, lat);
      // Byte bit plays no part in the word
      ref_mem[{a[15:1], 1'b0}] = d;
   endtask

   task automatic do_read(input string test, input cache_geom_pkg::addr_t a,
                          output bit hit, output int lat);
      cache_geom_pkg::word_t data;
      cache_geom_pkg::addr_t key;
      key = {a[15:1], 1'b0};
      if (!ref_mem.exists(key)) begin
         $display("%s: read of address %h that was never written", test, a);
         stop_with_failure();
      end
      issue_request(test, 1'b0, a, 16'h0000, data, hit, lat);
      check_value(test, $sformatf("read data at %h", a), ref_mem[key], data);
   endtask

   // Write-allocate on a cold line, then a 2-cycle hit
   task automatic cold_write_then_read();
      string name = "cold_write_read";
      bit hit;
      int lat;
      do_write(name, 16'h0a40, 16'hc3a5, hit);
      check_value(name, "cache_hit on write", 1'b0, hit);
      do_read(name, 16'h0a40, hit, lat);
      check_value(name, "cache_hit on read", 1'b1, hit);
      check_value(name, "read latency", HIT_LATENCY, lat);
   endtask

   // Only the first write of the line misses
   task automatic fill_whole_line();
      string name = "full_line";
      cache_geom_pkg::addr_t a;
      bit hit;
      int lat;
      for (int w = 0; w < cache_geom_pkg::WORDS_PER_LINE; w++) begin
         a = cache_geom_pkg::addr_t'(16'h1280 + 2 * w);
         do_write(name, a, cache_geom_pkg::word_t'(16'h5a00 + w * 16'h0111), hit);
         check_value(name, $sformatf("cache_hit on write %0d", w), w != 0, hit);
      end
      for (int w = 0; w < cache_geom_pkg::WORDS_PER_LINE; w++) begin
         a = cache_geom_pkg::addr_t'(16'h1280 + 2 * w);
         do_read(name, a, hit, lat);
         check_value(name, $sformatf("cache_hit on read %0d", w), 1'b1, hit);
         check_value(name, "read latency", HIT_LATENCY, lat);
      end
   endtask

   // A and B share index 0x6c with tags 0 and 5
   task automatic evict_dirty_line();
      string name = "dirty_eviction";
      bit hit;
      int lat;
      do_write(name, 16'h0360, 16'h1357, hit);
      do_write(name, 16'h2b60, 16'h2468, hit);
      check_value(name, "cache_hit on conflicting write", 1'b0, hit);
      // A comes back only through write-back and refill
      do_read(name, 16'h0360, hit, lat);
      check_value(name, "cache_hit on evicted read", 1'b0, hit);
      do_read(name, 16'h2b60, hit, lat);
      check_value(name, "cache_hit on second evicted read", 1'b0, hit);
   endtask

   // Tags and indexes 0 to 3, so lines get evicted often
   task automatic run_random_traffic();
      string name = "random_traffic";
      cache_geom_pkg::addr_t written [$];
      cache_geom_pkg::addr_t a;
      logic [31:0] r;
      bit hit;
      int lat;
      for (int n = 0; n < RANDOM_OPS; n++) begin
         rng_q = xorshift32(rng_q);
         r = rng_q;
         if (written.size() == 0 || r[0]) begin
            // Random byte bit too
            a = {3'b000, r[2:1], 6'b000000, r[4:3], r[6:5], r[7]};
            do_write(name, a, r[31:16], hit);
            written.push_back(a);
         end else begin
            a = written[r[15:8] % written.size()];
            do_read(name, a, hit, lat);
         end
      end
   endtask

   // Both strobes in IDLE lock the controller until reset
   task automatic lock_in_error_state();
      string name = "error_state";
      bit hit;
      int lat;
      addr = 16'h4e18;
      wdata = 16'h0f0f;
      rd = 1'b1;
      wr = 1'b1;
      repeat (ERROR_HOLD) begin
         @(posedge clk);
         @(negedge clk);
         check_value(name, "err with both strobes", 1'b1, err);
         check_value(name, "done in error", 1'b0, done);
      end
      @(posedge clk);
      #DRIVE_DELAY;
      rd = 1'b0;
      wr = 1'b0;
      repeat (4) begin
         @(posedge clk);
         @(negedge clk);
         check_value(name, "err after strobes drop", 1'b1, err);
         check_value(name, "done in error", 1'b0, done);
      end
      @(posedge clk);
      #DRIVE_DELAY;
      apply_reset();
      check_value(name, "err after reset", 1'b0, err);
      // Dirty lines are lost on reset
      ref_mem.delete();
      do_write(name, 16'h4e18, 16'h7e81, hit);
      do_read(name, 16'h4e18, hit, lat);
      check_value(name, "cache_hit after reset", 1'b1, hit);
   endtask

   initial begin
      rst = 1'b1;
      addr = '0;
      wdata = '0;
      rd = 1'b0;
      wr = 1'b0;
      apply_reset();
      cold_write_then_read();
      fill_whole_line();
      evict_dirty_line();
      run_random_traffic();
      lock_in_error_state();
      if (dut_i.props_i.fail_count == 0) begin
         $display("TEST OK");
         $finish;
      end else begin
         stop_with_failure();
      end
   end

   // Any bound property failure ends the run at once
   initial begin
      wait (dut_i.props_i.fail_count != 0);
      $display("A protocol assertion on the DUT failed");
      stop_with_failure();
   end

   // Every request gets the full miss bound
   initial begin
      repeat (N_REQUESTS * MISS_BOUND + EXTRA_CYCLES) @(posedge clk);
      $display("Timeout: tests did not finish in %0d cycles",
               N_REQUESTS * MISS_BOUND + EXTRA_CYCLES);
      stop_with_failure();
   end

endmodule

`default_nettype wire
